// File: build.f
panel_pkg.sv
serial_pkg.sv
rx_panel_input.sv
panel_keys.sv
panel_report.sv
tx_fifo.sv
uart_tx.sv
control_panel.sv
tb_control_panel.sv

// File: tb_control_panel.sv
// Table-driven testbench for the control panel with a TXD frame decoder and watchdog
`default_nettype none

module tb_control_panel;

	localparam int CLK_SYS_HZ      = 1000;
	localparam int UART_BAUD       = 250;
	localparam int TIMER_CYCLE_MS  = 20;
	localparam int FIFO_DEPTH      = 8;
	localparam int CLKS_PER_BIT    = CLK_SYS_HZ / UART_BAUD;
	localparam int FRAME_BYTES     = 5;
	localparam int FRAME_CYCLES    = FRAME_BYTES * (10 * CLKS_PER_BIT + 1);
	localparam int WATCHDOG_MARGIN = 2000;
	localparam logic [7:0] REPORT_CMD = 8'hC0;

	// One stimulus row with the values expected after it
	typedef struct packed {
		serial_pkg::byte_t       cmd;
		logic                    p0;
		panel_pkg::data_word_t   w;
		logic [6:0]              cpu;
		logic [7:0]              wait_cyc;
		logic                    frame_taken;
		panel_pkg::report_word_t frame;
		panel_pkg::data_word_t   exp_kl;
		panel_pkg::reg_select_t  exp_rs;
		logic [4:0]              exp_gated;
		logic [4:0]              exp_levels;
		logic                    exp_stop_n;
		logic                    exp_start;
		logic                    exp_stop;
		logic [3:0]              tick_min;
		logic [3:0]              tick_max;
	} row_t;

	logic                     clk_sys = 1'b0;
	logic                     hlt_n;
	serial_pkg::byte_stream_t rx_in;
	logic                     txd;
	logic                     p0;
	panel_pkg::data_word_t    w;
	logic                     p;
	logic                     mc_0;
	logic                     alarm;
	logic                     wait_st;
	logic                     irq;
	logic                     q;
	logic                     run;
	panel_pkg::data_word_t    kl;
	panel_pkg::reg_select_t   reg_sel;
	logic                     work;
	logic                     start;
	logic                     stop;
	logic                     mode;
	logic                     stop_n;
	logic                     dcl;
	logic                     step;
	logic                     fetch;
	logic                     store;
	logic                     cycle;
	logic                     load;
	logic                     bin;
	logic                     oprq;
	logic                     zegar;

	int                  seed = 12;
	row_t                stim_rows[$];
	serial_pkg::byte_t   exp_bytes[$];
	logic                rows_ready = 1'b0;
	logic                monitor_on = 1'b0;
	int                  start_cnt = 0;
	int                  stop_cnt = 0;
	int                  zegar_cnt = 0;

	// Reference state of the panel as the host commands describe it
	panel_pkg::fn_keys_t    m_keys = '0;
	panel_pkg::rotary_pos_t m_rotary = '0;
	panel_pkg::data_word_t  m_kl = '0;
	logic                   m_stop_n = 1'b0;

	control_panel #(
		.CLK_SYS_HZ     (CLK_SYS_HZ),
		.UART_BAUD      (UART_BAUD),
		.TIMER_CYCLE_MS (TIMER_CYCLE_MS),
		.FIFO_DEPTH     (FIFO_DEPTH)
	) dut_i (
		.clk_sys (clk_sys),
		.hlt_n   (hlt_n),
		.rx_in   (rx_in),
		.txd     (txd),
		.p0      (p0),
		.w       (w),
		.p       (p),
		.mc_0    (mc_0),
		.alarm   (alarm),
		.wait_st (wait_st),
		.irq     (irq),
		.q       (q),
		.run     (run),
		.kl      (kl),
		.reg_sel (reg_sel),
		.work    (work),
		.start   (start),
		.stop    (stop),
		.mode    (mode),
		.stop_n  (stop_n),
		.dcl     (dcl),
		.step    (step),
		.fetch   (fetch),
		.store   (store),
		.cycle   (cycle),
		.load    (load),
		.bin     (bin),
		.oprq    (oprq),
		.zegar   (zegar)
	);

	always #10 clk_sys = ~clk_sys;

	// Pulses are counted on the rising edge and read back on the falling edge
	always @(posedge clk_sys) begin
		if (start) start_cnt <= start_cnt + 1;
		if (stop) stop_cnt <= stop_cnt + 1;
		if (zegar) zegar_cnt <= zegar_cnt + 1;
	end

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	task automatic check_value(input logic [39:0] actual, input logic [39:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	function automatic serial_pkg::byte_t key_cmd(input logic [3:0] idx, input logic level);
		return {3'b000, level, idx};
	endfunction

	function automatic serial_pkg::byte_t rotary_cmd(input logic [3:0] pos);
		return {4'b0100, pos};
	endfunction

	function automatic serial_pkg::byte_t data_cmd(input logic [1:0] sel, input logic [3:0] val);
		return {2'b10, sel, val};
	endfunction

	// One-hot select for positions 0 to 6 and a user register number above that
	function automatic panel_pkg::reg_select_t expect_reg_sel(input logic [3:0] pos);
		panel_pkg::reg_select_t rs;
		rs = '0;
		if (pos < 4'd7) begin
			rs = panel_pkg::reg_select_t'(11'd1 << pos);
		end else if (pos != 4'd15) begin
			rs.wre = 1'b1;
			{rs.rsc, rs.rsb, rs.rsa} = 3'(pos - 4'd7);
		end
		return rs;
	endfunction

	task automatic add_row(input serial_pkg::byte_t cmd, input logic p0_val, input int wait_cyc,
		input logic frame_taken, input int tick_min, input int tick_max);
		row_t              r;
		panel_pkg::lamps_t lamps;
		logic [3:0]        idx;
		logic              old_level;
		r = '0;
		r.cmd = cmd;
		r.p0 = p0_val;
		r.wait_cyc = 8'(wait_cyc);
		r.frame_taken = frame_taken;
		r.tick_min = 4'(tick_min);
		r.tick_max = 4'(tick_max);
		r.w = 16'($random(seed));
		r.cpu = 7'($random(seed));
		idx = cmd[3:0];
		case (cmd[7:6])
			2'd0: begin
				if (idx < 4'd12) begin
					old_level = m_keys[idx];
					m_keys[idx] = cmd[4];
					if (idx == 4'd3 && cmd[4] && !old_level) m_stop_n = ~m_stop_n;
					if (idx == 4'd0) begin
						r.exp_start = cmd[4] & ~old_level;
						r.exp_stop = ~cmd[4] & old_level;
					end
				end
			end
			2'd1: m_rotary = idx;
			2'd2: begin
				case (cmd[5:4])
					2'd0: m_kl[15:12] = cmd[3:0];
					2'd1: m_kl[11:8] = cmd[3:0];
					2'd2: m_kl[7:4] = cmd[3:0];
					default: m_kl[3:0] = cmd[3:0];
				endcase
			end
			default: begin
			end
		endcase
		// cpu holds p, mc_0, alarm, wait_st, irq, q, run from the top bit down
		lamps.mode = m_keys[1];
		lamps.stop_n = m_stop_n;
		lamps.zeg = m_keys[2];
		lamps.q = r.cpu[1];
		lamps.p = r.cpu[6];
		lamps.mc_n = ~r.cpu[5];
		lamps.irq = r.cpu[2];
		lamps.run = r.cpu[0];
		lamps.wait_st = r.cpu[3];
		lamps.alarm = r.cpu[4];
		r.frame = {4'hA, m_rotary, r.w[7:0], r.w[15:8], 6'd0, lamps};
		r.exp_kl = m_kl;
		r.exp_rs = expect_reg_sel(m_rotary);
		r.exp_gated = {m_keys[5], m_keys[6], m_keys[7], m_keys[8], m_keys[9]} & {5{p0_val}};
		// Levels of start, mode, clear, step and oprq in that order
		r.exp_levels = {m_keys[0], m_keys[1], m_keys[11], m_keys[4], m_keys[10]};
		r.exp_stop_n = m_stop_n;
		stim_rows.push_back(r);
	endtask

	task automatic build_table();
		int i;
		int k;
		for (i = 0; i < 8; i++) begin
			add_row(data_cmd(2'(i), 4'($random(seed))), 1'b0, 0, 1'b0, 0, 0);
		end
		for (i = 0; i < 16; i++) begin
			add_row(rotary_cmd(4'(i)), 1'b0, 0, 1'b0, 0, 0);
		end
		add_row(rotary_cmd(4'd9), 1'b0, 0, 1'b0, 0, 0);
		// Each memory key seen with p0 high and low
		// Key 12 leaves the state alone
		for (k = int'(panel_pkg::fn_fetch); k <= int'(panel_pkg::fn_bin); k++) begin
			add_row(key_cmd(4'(k), 1'b1), 1'b1, 0, 1'b0, 0, 0);
			add_row(key_cmd(4'd12, 1'b1), 1'b0, 0, 1'b0, 0, 0);
			add_row(key_cmd(4'(k), 1'b0), 1'b1, 0, 1'b0, 0, 0);
		end
		for (i = 0; i < 3; i++) begin
			add_row(key_cmd(panel_pkg::fn_stopn, 1'b1), 1'b0, 0, 1'b0, 0, 0);
			add_row(key_cmd(panel_pkg::fn_stopn, 1'b0), 1'b0, 0, 1'b0, 0, 0);
		end
		add_row(key_cmd(panel_pkg::fn_start, 1'b1), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_start, 1'b0), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_mode, 1'b1), 1'b0, 0, 1'b0, 0, 0);
		// Plain level keys pressed and released one at a time
		add_row(key_cmd(panel_pkg::fn_step, 1'b1), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_step, 1'b0), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_oprq, 1'b1), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_oprq, 1'b0), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_clear, 1'b1), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_clear, 1'b0), 1'b0, 0, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_clock, 1'b1), 1'b0, 200, 1'b0, 9, 11);
		// Second and fourth requests land while the producer is still sending
		add_row(REPORT_CMD, 1'b0, 0, 1'b1, 0, 1);
		add_row(REPORT_CMD, 1'b0, 3, 1'b0, 0, 1);
		add_row(REPORT_CMD, 1'b0, 0, 1'b1, 0, 1);
		add_row(REPORT_CMD, 1'b0, 0, 1'b0, 0, 1);
		add_row(key_cmd(panel_pkg::fn_clock, 1'b0), 1'b0, 200, 1'b0, 0, 1);
		add_row(key_cmd(4'd12, 1'b0), 1'b0, 200, 1'b0, 0, 0);
		add_row(key_cmd(panel_pkg::fn_mode, 1'b0), 1'b0, 0, 1'b0, 0, 0);
		add_row(REPORT_CMD, 1'b1, 0, 1'b1, 0, 0);
	endtask

	task automatic apply_row(input row_t r);
		int start0;
		int stop0;
		int tick0;
		int ticks;
		int b;
		start0 = start_cnt;
		stop0 = stop_cnt;
		tick0 = zegar_cnt;
		@(posedge clk_sys);
		rx_in <= {1'b1, r.cmd};
		p0 <= r.p0;
		w <= r.w;
		{p, mc_0, alarm, wait_st, irq, q, run} <= r.cpu;
		if (r.frame_taken) begin
			for (b = FRAME_BYTES - 1; b >= 0; b--) exp_bytes.push_back(r.frame[b*8 +: 8]);
		end
		@(posedge clk_sys);
		rx_in <= {1'b0, r.cmd};
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(kl, r.exp_kl, "kl");
		check_value(reg_sel, r.exp_rs, "reg_sel");
		check_value({fetch, store, cycle, load, bin}, r.exp_gated, "gated memory keys");
		check_value({work, mode, dcl, step, oprq}, r.exp_levels, "key level outputs");
		check_value(stop_n, r.exp_stop_n, "stop_n");
		repeat (r.wait_cyc) @(negedge clk_sys);
		check_value(start_cnt - start0, r.exp_start, "start pulse count");
		check_value(stop_cnt - stop0, r.exp_stop, "stop pulse count");
		ticks = zegar_cnt - tick0;
		check_value(ticks >= r.tick_min && ticks <= r.tick_max, 1'b1,
			$sformatf("zegar count %0d within %0d..%0d", ticks, r.tick_min, r.tick_max));
	endtask

	// TXD decoder that samples each bit near its middle
	initial begin
		serial_pkg::byte_t got;
		int                i;
		wait (monitor_on);
		forever begin
			@(negedge txd);
			repeat (CLKS_PER_BIT / 2) @(negedge clk_sys);
			check_value(txd, 1'b0, "TXD start bit");
			for (i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk_sys);
				got[i] = txd;
			end
			repeat (CLKS_PER_BIT) @(negedge clk_sys);
			check_value(txd, 1'b1, "TXD stop bit");
			if (exp_bytes.size() == 0) begin
				$display("TXD sent byte %h at %0t while no report frame was pending", got, $time);
				abort_run();
			end else begin
				check_value(got, exp_bytes.pop_front(), "TXD report byte");
			end
		end
	end

	initial begin
		wait (rows_ready);
		repeat (stim_rows.size() * FRAME_BYTES * 40 + WATCHDOG_MARGIN) @(posedge clk_sys);
		$display("Timeout: the run did not finish in the allowed number of clock cycles");
		abort_run();
	end

	initial begin
		hlt_n = 1'b1;
		rx_in = '0;
		p0 = 1'b0;
		w = '0;
		{p, mc_0, alarm, wait_st, irq, q, run} = '0;
		build_table();
		rows_ready = 1'b1;
		repeat (10) @(posedge clk_sys);
		hlt_n <= 1'b0;
		@(negedge clk_sys);
		check_value(txd, 1'b1, "txd after reset");
		check_value({start, stop, stop_n, zegar, work}, 5'd0, "key strobes after reset");
		check_value(kl, 16'd0, "kl after reset");
		monitor_on = 1'b1;
		foreach (stim_rows[i]) apply_row(stim_rows[i]);
		while (exp_bytes.size() != 0) @(negedge clk_sys);
		// Quiet period in which a stray frame would show up
		repeat (2 * FRAME_CYCLES) @(negedge clk_sys);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: control_panel.sv
// Operator control panel top with host command input and serial lamp reports
`default_nettype none

module control_panel #(
	parameter int CLK_SYS_HZ     = 1000,
	parameter int UART_BAUD      = 250,
	parameter int TIMER_CYCLE_MS = 20,
	parameter int FIFO_DEPTH     = 8
) (
	input  wire logic                     clk_sys,
	input  wire logic                     hlt_n,
	input  wire serial_pkg::byte_stream_t rx_in,
	output logic                          txd,
	input  wire logic                     p0,
	input  wire panel_pkg::data_word_t    w,
	input  wire logic                     p,
	input  wire logic                     mc_0,
	input  wire logic                     alarm,
	input  wire logic                     wait_st,
	input  wire logic                     irq,
	input  wire logic                     q,
	input  wire logic                     run,
	output panel_pkg::data_word_t         kl,
	output panel_pkg::reg_select_t        reg_sel,
	output logic                          work,
	output logic                          start,
	output logic                          stop,
	output logic                          mode,
	output logic                          stop_n,
	output logic                          dcl,
	output logic                          step,
	output logic                          fetch,
	output logic                          store,
	output logic                          cycle,
	output logic                          load,
	output logic                          bin,
	output logic                          oprq,
	output logic                          zegar
);

	localparam int CLKS_PER_BIT = CLK_SYS_HZ / UART_BAUD;

	panel_pkg::fn_keys_t      fn_keys;
	panel_pkg::rotary_pos_t   rotary;
	panel_pkg::lamps_t        lamps;
	logic                     report_req;
	serial_pkg::byte_stream_t report_stream;
	logic                     report_ready;
	logic                     fifo_valid;
	serial_pkg::byte_t        fifo_data;
	logic                     uart_ready;

	rx_panel_input rx_panel_input_i (
		.clk_sys    (clk_sys),
		.hlt_n      (hlt_n),
		.rx_in      (rx_in),
		.fn_keys    (fn_keys),
		.rotary     (rotary),
		.kl         (kl),
		.report_req (report_req)
	);

	panel_keys #(
		.CLK_SYS_HZ     (CLK_SYS_HZ),
		.TIMER_CYCLE_MS (TIMER_CYCLE_MS)
	) panel_keys_i (
		.clk_sys (clk_sys),
		.hlt_n   (hlt_n),
		.fn_keys (fn_keys),
		.rotary  (rotary),
		.p0      (p0),
		.work    (work),
		.start   (start),
		.stop    (stop),
		.mode    (mode),
		.stop_n  (stop_n),
		.dcl     (dcl),
		.step    (step),
		.fetch   (fetch),
		.store   (store),
		.cycle   (cycle),
		.load    (load),
		.bin     (bin),
		.oprq    (oprq),
		.zegar   (zegar),
		.reg_sel (reg_sel)
	);

	// Lamp word, the microcycle lamp shows the inverted mc_0
	assign lamps.mode    = mode;
	assign lamps.stop_n  = stop_n;
	assign lamps.zeg     = fn_keys[panel_pkg::fn_clock];
	assign lamps.q       = q;
	assign lamps.p       = p;
	assign lamps.mc_n    = ~mc_0;
	assign lamps.irq     = irq;
	assign lamps.run     = run;
	assign lamps.wait_st = wait_st;
	assign lamps.alarm   = alarm;

	panel_report panel_report_i (
		.clk_sys    (clk_sys),
		.hlt_n      (hlt_n),
		.report_req (report_req),
		.w          (w),
		.lamps      (lamps),
		.rotary     (rotary),
		.out_stream (report_stream),
		.out_ready  (report_ready)
	);

	tx_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) tx_fifo_i (
		.clk_sys   (clk_sys),
		.hlt_n     (hlt_n),
		.in_stream (report_stream),
		.in_ready  (report_ready),
		.out_valid (fifo_valid),
		.out_data  (fifo_data),
		.out_ready (uart_ready)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) uart_tx_i (
		.clk_sys  (clk_sys),
		.hlt_n    (hlt_n),
		.in_valid (fifo_valid),
		.in_data  (fifo_data),
		.in_ready (uart_ready),
		.txd      (txd)
	);

endmodule

`default_nettype wire

// File: uart_tx.sv
// UART transmitter sending 8N1 bytes on TXD, LSB first
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 4
) (
	input  wire logic               clk_sys,
	input  wire logic               hlt_n,
	input  wire logic               in_valid,
	input  wire serial_pkg::byte_t  in_data,
	output logic                    in_ready,
	output logic                    txd
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} tx_state_t;

	tx_state_t         state;
	logic [CNT_W-1:0]  bit_cnt;
	logic [2:0]        bit_idx;
	serial_pkg::byte_t shift;
	logic              bit_done;

	assign in_ready = (state == st_idle);
	assign bit_done = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			state   <= st_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			txd     <= 1'b1;
		end else begin
			bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
			case (state)
				st_idle: begin
					bit_cnt <= '0;
					if (in_valid) begin
						state <= st_start;
						txd   <= 1'b0;
					end
				end
				st_start: begin
					if (bit_done) begin
						state   <= st_data;
						bit_idx <= '0;
						txd     <= shift[0];
					end
				end
				st_data: begin
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							state <= st_stop;
							txd   <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd     <= shift[1];
						end
					end
				end
				st_stop: begin
					if (bit_done) state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Shift register loads on accept and moves one bit per data period
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && in_valid) begin
			shift <= in_data;
		end else if (state == st_data && bit_done) begin
			shift <= shift >> 1;
		end
	end

endmodule

`default_nettype wire

// File: tx_fifo.sv
// Byte FIFO between the report producer and the UART transmitter
`default_nettype none

module tx_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire logic                     clk_sys,
	input  wire logic                     hlt_n,
	input  wire serial_pkg::byte_stream_t in_stream,
	output logic                          in_ready,
	output logic                          out_valid,
	output serial_pkg::byte_t             out_data,
	input  wire logic                     out_ready
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	serial_pkg::byte_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    fill;
	logic              do_write;
	logic              do_read;

	assign in_ready  = (fill != (PTR_W + 1)'(FIFO_DEPTH));
	assign out_valid = (fill != '0);
	assign out_data  = mem[rd_ptr];

	assign do_write = in_stream.valid & in_ready;
	assign do_read  = out_valid & out_ready;

	always_ff @(posedge clk_sys) begin
		if (do_write) begin
			mem[wr_ptr] <= in_stream.data;
		end
	end

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (do_write) wr_ptr <= wr_ptr + 1'b1;
			if (do_read) rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: panel_report.sv
// Lamp report producer that snapshots the panel and emits a five-byte frame
`default_nettype none

module panel_report (
	input  wire logic                   clk_sys,
	input  wire logic                   hlt_n,
	input  wire logic                   report_req,
	input  wire panel_pkg::data_word_t  w,
	input  wire panel_pkg::lamps_t      lamps,
	input  wire panel_pkg::rotary_pos_t rotary,
	output serial_pkg::byte_stream_t    out_stream,
	input  wire logic                   out_ready
);

	typedef enum logic {
		st_idle,
		st_send
	} report_state_t;

	report_state_t           state;
	panel_pkg::report_word_t snap;
	logic [2:0]              byte_idx;
	serial_pkg::byte_t       cur_byte;

	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			state    <= st_idle;
			byte_idx <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (report_req) begin
						byte_idx <= '0;
						state    <= st_send;
					end
				end
				st_send: begin
					// Requests arriving here are dropped
					if (out_ready) begin
						if (byte_idx == 3'd4) begin
							state <= st_idle;
						end else begin
							byte_idx <= byte_idx + 1'b1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Frame contents are frozen at the accepted request
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && report_req) begin
			snap <= {4'hA, rotary, w[7:0], w[15:8], 6'b000000, lamps};
		end
	end

	always_comb begin
		case (byte_idx)
			3'd0: cur_byte = snap[39:32];
			3'd1: cur_byte = snap[31:24];
			3'd2: cur_byte = snap[23:16];
			3'd3: cur_byte = snap[15:8];
			default: cur_byte = snap[7:0];
		endcase
	end

	assign out_stream.valid = (state == st_send);
	assign out_stream.data  = cur_byte;

endmodule

`default_nettype wire

// File: panel_keys.sv
// Key strobes for the CPU, stop toggle, rotary decode and real-time clock tick
`default_nettype none

module panel_keys #(
	parameter int CLK_SYS_HZ     = 1000,
	parameter int TIMER_CYCLE_MS = 20
) (
	input  wire logic                   clk_sys,
	input  wire logic                   hlt_n,
	input  wire panel_pkg::fn_keys_t    fn_keys,
	input  wire panel_pkg::rotary_pos_t rotary,
	input  wire logic                   p0,
	output logic                        work,
	output logic                        start,
	output logic                        stop,
	output logic                        mode,
	output logic                        stop_n,
	output logic                        dcl,
	output logic                        step,
	output logic                        fetch,
	output logic                        store,
	output logic                        cycle,
	output logic                        load,
	output logic                        bin,
	output logic                        oprq,
	output logic                        zegar,
	output panel_pkg::reg_select_t      reg_sel
);

	localparam int TICK_CYCLES = CLK_SYS_HZ * TIMER_CYCLE_MS / 1000;
	localparam int TICK_W      = $clog2(TICK_CYCLES + 1);

	logic              prev_work;
	logic              prev_stopn;
	logic              clock_key;
	logic [TICK_W-1:0] tick_cnt;
	logic [3:0]        rs_index;

	assign work = fn_keys[panel_pkg::fn_start];
	assign start = work & ~prev_work;
	assign stop  = ~work & prev_work;

	assign mode = fn_keys[panel_pkg::fn_mode];
	assign dcl  = fn_keys[panel_pkg::fn_clear];
	assign step = fn_keys[panel_pkg::fn_step];
	assign oprq = fn_keys[panel_pkg::fn_oprq];

	// Memory keys only act while the CPU allows it
	assign fetch = fn_keys[panel_pkg::fn_fetch] & p0;
	assign store = fn_keys[panel_pkg::fn_store] & p0;
	assign cycle = fn_keys[panel_pkg::fn_cycle] & p0;
	assign load  = fn_keys[panel_pkg::fn_load] & p0;
	assign bin   = fn_keys[panel_pkg::fn_bin] & p0;

	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			prev_work  <= 1'b0;
			prev_stopn <= 1'b0;
			stop_n     <= 1'b0;
		end else begin
			prev_work  <= work;
			prev_stopn <= fn_keys[panel_pkg::fn_stopn];
			if (fn_keys[panel_pkg::fn_stopn] && !prev_stopn) begin
				stop_n <= ~stop_n;
			end
		end
	end

	// Rotary positions 7 to 14 pick one of eight user registers
	assign rs_index = rotary - 4'd7;

	always_comb begin
		reg_sel = '0;
		case (rotary)
			4'd0: reg_sel.wkb = 1'b1;
			4'd1: reg_sel.wrz = 1'b1;
			4'd2: reg_sel.wrs = 1'b1;
			4'd3: reg_sel.wir = 1'b1;
			4'd4: reg_sel.war = 1'b1;
			4'd5: reg_sel.wac = 1'b1;
			4'd6: reg_sel.wic = 1'b1;
			4'd15: reg_sel = '0;
			default: begin
				reg_sel.wre = 1'b1;
				{reg_sel.rsc, reg_sel.rsb, reg_sel.rsa} = rs_index[2:0];
			end
		endcase
	end

	assign clock_key = fn_keys[panel_pkg::fn_clock];

	// Tick timer, held at zero while the clock key is off
	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			tick_cnt <= '0;
			zegar    <= 1'b0;
		end else if (!clock_key) begin
			tick_cnt <= '0;
			zegar    <= 1'b0;
		end else if (tick_cnt == TICK_W'(TICK_CYCLES - 1)) begin
			tick_cnt <= '0;
			zegar    <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			zegar    <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rx_panel_input.sv
// Host command decoder that holds the key levels, rotary position and data keys
`default_nettype none

module rx_panel_input (
	input  wire logic                      clk_sys,
	input  wire logic                      hlt_n,
	input  wire serial_pkg::byte_stream_t  rx_in,
	output panel_pkg::fn_keys_t            fn_keys,
	output panel_pkg::rotary_pos_t         rotary,
	output panel_pkg::data_word_t          kl,
	output logic                           report_req
);

	serial_pkg::cmd_op_t op;
	logic [3:0]          key_idx;
	logic [3:0]          nibble_val;
	logic [1:0]          nibble_sel;

	assign op         = serial_pkg::cmd_op_t'(rx_in.data[7:6]);
	assign key_idx    = rx_in.data[3:0];
	assign nibble_val = rx_in.data[3:0];
	assign nibble_sel = rx_in.data[5:4];

	always_ff @(posedge clk_sys or posedge hlt_n) begin
		if (hlt_n) begin
			fn_keys    <= '0;
			rotary     <= '0;
			kl         <= '0;
			report_req <= 1'b0;
		end else begin
			report_req <= 1'b0;
			if (rx_in.valid) begin
				case (op)
					serial_pkg::op_key: begin
						// Keys 12 to 15 do not exist on the panel
						if (key_idx < 4'(panel_pkg::FN_KEY_COUNT)) begin
							fn_keys[key_idx] <= rx_in.data[4];
						end
					end
					serial_pkg::op_rotary: begin
						rotary <= rx_in.data[3:0];
					end
					serial_pkg::op_data: begin
						// Nibble 0 is the most significant one
						kl[{~nibble_sel, 2'b00} +: 4] <= nibble_val;
					end
					serial_pkg::op_report: begin
						report_req <= 1'b1;
					end
					default: begin
						report_req <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: serial_pkg.sv
// Serial link types for host command bytes and internal byte streams
`default_nettype none

package serial_pkg;

	typedef logic [7:0] byte_t;

	// Opcode in bits 7:6 of a host command byte
	typedef enum logic [1:0] {
		op_key    = 2'd0,
		op_rotary = 2'd1,
		op_data   = 2'd2,
		op_report = 2'd3
	} cmd_op_t;

	typedef struct packed {
		logic  valid;
		byte_t data;
	} byte_stream_t;

endpackage

`default_nettype wire

// File: panel_pkg.sv
// Control panel types for keys, rotary switch, register select and lamps
`default_nettype none

package panel_pkg;

	localparam int FN_KEY_COUNT = 12;

	// Function key positions within the key level vector
	typedef enum logic [3:0] {
		fn_start = 4'd0,
		fn_mode  = 4'd1,
		fn_clock = 4'd2,
		fn_stopn = 4'd3,
		fn_step  = 4'd4,
		fn_fetch = 4'd5,
		fn_store = 4'd6,
		fn_cycle = 4'd7,
		fn_load  = 4'd8,
		fn_bin   = 4'd9,
		fn_oprq  = 4'd10,
		fn_clear = 4'd11
	} fn_key_t;

	typedef logic [FN_KEY_COUNT-1:0] fn_keys_t;
	typedef logic [3:0] rotary_pos_t;
	typedef logic [15:0] data_word_t;

	// Five report bytes, first byte in the top bits
	typedef logic [39:0] report_word_t;

	// Register select lines towards the CPU
	typedef struct packed {
		logic wre;
		logic rsc;
		logic rsb;
		logic rsa;
		logic wic;
		logic wac;
		logic war;
		logic wir;
		logic wrs;
		logic wrz;
		logic wkb;
	} reg_select_t;

	// Lamp states in report order, mode is the top bit
	typedef struct packed {
		logic mode;
		logic stop_n;
		logic zeg;
		logic q;
		logic p;
		logic mc_n;
		logic irq;
		logic run;
		logic wait_st;
		logic alarm;
	} lamps_t;

endpackage

`default_nettype wire
